// File: sim.f
+incdir+src
src/axi_sram_pkg.sv
src/axi_write_engine.sv
src/sram_bank.sv
src/axi_read_engine.sv
src/axi_sram_slave.sv
testbench/tb_axi_sram_slave.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_axi_sram_slave

out=$(./obj_dir/Vtb_axi_sram_slave)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi

// File: testbench/tb_axi_sram_slave.sv
module tb_axi_sram_slave;
    import axi_sram_pkg::*;

    typedef struct {
        bit     is_wr;
        bit     stall;   // random ready gaps on B or R
        id_t    id;
        addr_t  addr;
        len_t   len;
        size_t  size;
        burst_t burst;
        data_t  base;    // beat k carries base plus k
        strb_t  strb;
        resp_t  exp;
    } row_t;

    localparam bit WR = 1'b1;
    localparam bit RD = 1'b0;

    logic ACLK = 1'b0;
    logic ARESETn;
    id_t awid, arid, bid, rid;
    addr_t awaddr, araddr;
    len_t awlen, arlen;
    size_t awsize, arsize;
    burst_t awburst, arburst;
    data_t wdata, rdata;
    strb_t wstrb;
    resp_t bresp, rresp;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rlast, rvalid, rready;

    row_t rows[$];
    logic [7:0] ref_mem [65536];   // byte model of the 64 KiB bank
    int n_checks, n_errors, cycle_cnt, cycle_limit;

    axi_sram_slave u_axi_sram_slave (.*);

    always #20 ACLK = ~ACLK;

    always @(posedge ACLK) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout, the DUT stopped responding after %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_resp(string name, resp_t exp, resp_t got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR t=%0t %s expected %s got %s", $time, name, exp.name(), got.name());
        end
    endtask

    task automatic check_data(string name, data_t exp, data_t got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR t=%0t %s expected %08h got %08h", $time, name, exp, got);
        end
    endtask

    task automatic check_id(string name, id_t exp, id_t got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR t=%0t %s expected %02h got %02h", $time, name, exp, got);
        end
    endtask

    task automatic check_last(string name, logic exp, logic got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR t=%0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic add_row(bit is_wr, bit stall, id_t id, addr_t addr, len_t len,
                           size_t size, burst_t burst, data_t base, strb_t strb, resp_t exp);
        row_t r;
        r.is_wr = is_wr;
        r.stall = stall;
        r.id    = id;
        r.addr  = addr;
        r.len   = len;
        r.size  = size;
        r.burst = burst;
        r.base  = is_wr ? base : $urandom;   // reads never use the data column
        r.strb  = strb;
        r.exp   = exp;
        rows.push_back(r);
    endtask

    task automatic model_write(input row_t r);
        logic [15:0] a;
        data_t d;
        int k;
        int lane;
        a = r.addr[15:0];   // wraps modulo 64 KiB
        for (k = 0; k <= int'(r.len); k++) begin
            d = r.base + data_t'(k);
            for (lane = 0; lane < 4; lane++) begin
                if (r.strb[lane])
                    ref_mem[{a[15:2], 2'b00} + 16'(lane)] = d[lane*8 +: 8];
            end
            if (r.burst == BURST_INCR)
                a = a + (16'd1 << r.size);
        end
    endtask

    function automatic data_t model_word(logic [15:0] a);
        return {ref_mem[{a[15:2], 2'b11}], ref_mem[{a[15:2], 2'b10}],
                ref_mem[{a[15:2], 2'b01}], ref_mem[{a[15:2], 2'b00}]};
    endfunction

    task automatic do_write(input row_t r);
        int k;
        logic done;
        @(posedge ACLK);
        awid    <= r.id;
        awaddr  <= r.addr;
        awlen   <= r.len;
        awsize  <= r.size;
        awburst <= r.burst;
        awvalid <= 1'b1;
        do @(negedge ACLK); while (!awready);   // transfer on the coming edge
        @(posedge ACLK);
        awvalid <= 1'b0;
        for (k = 0; k <= int'(r.len); k++) begin
            wdata  <= r.base + data_t'(k);
            wstrb  <= r.strb;
            wlast  <= (k == int'(r.len));
            wvalid <= 1'b1;
            do @(negedge ACLK); while (!wready);
            @(posedge ACLK);
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
        done = 1'b0;
        while (!done) begin
            bready <= r.stall ? ($urandom % 4 != 0) : 1'b1;
            @(negedge ACLK);
            if (bvalid && bready) begin
                check_resp("bresp", r.exp, bresp);
                check_id("bid", r.id, bid);
                done = 1'b1;
            end
            @(posedge ACLK);
        end
        bready <= 1'b0;
        if (r.exp == RESP_OKAY)
            model_write(r);   // error bursts leave memory alone
    endtask

    task automatic do_read(input row_t r);
        int k;
        logic done;
        logic [15:0] a;
        data_t exp_data;
        a = r.addr[15:0];
        @(posedge ACLK);
        arid    <= r.id;
        araddr  <= r.addr;
        arlen   <= r.len;
        arsize  <= r.size;
        arburst <= r.burst;
        arvalid <= 1'b1;
        do @(negedge ACLK); while (!arready);
        @(posedge ACLK);
        arvalid <= 1'b0;
        for (k = 0; k <= int'(r.len); k++) begin
            exp_data = (r.exp == RESP_OKAY) ? model_word(a) : '0;
            done = 1'b0;
            while (!done) begin
                rready <= r.stall ? ($urandom % 4 != 0) : 1'b1;
                @(negedge ACLK);
                if (rvalid && rready) begin
                    check_resp("rresp", r.exp, rresp);
                    check_id("rid", r.id, rid);
                    check_data("rdata", exp_data, rdata);
                    check_last("rlast", k == int'(r.len), rlast);
                    done = 1'b1;
                end
                @(posedge ACLK);
            end
            if (r.burst == BURST_INCR)
                a = a + (16'd1 << r.size);
        end
        rready <= 1'b0;
    endtask

    initial begin
        int err_before;
        void'($urandom(32'h7dd8_ad6c));
        ARESETn <= 1'b0;
        awid    <= '0;
        awaddr  <= '0;
        awlen   <= '0;
        awsize  <= '0;
        awburst <= BURST_INCR;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wlast   <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        arid    <= '0;
        araddr  <= '0;
        arlen   <= '0;
        arsize  <= '0;
        arburst <= BURST_INCR;
        arvalid <= 1'b0;
        rready  <= 1'b0;

        add_row(WR, 0, 8'h11, 32'h0000, 4'd3, 3'd2, BURST_INCR, 32'hA000_0000, 4'hF, RESP_OKAY);
        add_row(RD, 0, 8'h12, 32'h0000, 4'd3, 3'd2, BURST_INCR, 32'h0, 4'h0, RESP_OKAY);
        add_row(WR, 0, 8'h21, 32'h0005, 4'd0, 3'd0, BURST_INCR, 32'h0000_5A00, 4'h2, RESP_OKAY);
        add_row(WR, 0, 8'h22, 32'h000A, 4'd0, 3'd1, BURST_INCR, 32'hBEEF_0000, 4'hC, RESP_OKAY);
        add_row(WR, 0, 8'h23, 32'h000C, 4'd1, 3'd1, BURST_INCR, 32'h0000_C0DE, 4'h3, RESP_OKAY);
        add_row(RD, 0, 8'h24, 32'h0000, 4'd3, 3'd2, BURST_INCR, 32'h0, 4'h0, RESP_OKAY);
        add_row(WR, 0, 8'h31, 32'h0100, 4'd2, 3'd2, BURST_FIXED, 32'h3000_0000, 4'hF, RESP_OKAY);
        add_row(RD, 0, 8'h32, 32'h0100, 4'd0, 3'd2, BURST_INCR, 32'h0, 4'h0, RESP_OKAY);
        add_row(WR, 0, 8'h41, 32'h0000, 4'd1, 3'd3, BURST_INCR, 32'hDEAD_0000, 4'hF, RESP_SLVERR);
        add_row(RD, 0, 8'h42, 32'h0000, 4'd1, 3'd3, BURST_INCR, 32'h0, 4'h0, RESP_SLVERR);
        add_row(WR, 0, 8'h43, 32'h1_0000, 4'd1, 3'd2, BURST_INCR, 32'hBAD0_0000, 4'hF, RESP_DECERR);
        add_row(RD, 0, 8'h44, 32'h1_0000, 4'd2, 3'd2, BURST_INCR, 32'h0, 4'h0, RESP_DECERR);
        add_row(RD, 0, 8'h45, 32'h0000, 4'd3, 3'd2, BURST_INCR, 32'h0, 4'h0, RESP_OKAY);
        // same kinds of traffic again with ready stalls
        add_row(WR, 1, 8'h51, 32'h0200, 4'd7, 3'd2, BURST_INCR, 32'h7700_0000, 4'hF, RESP_OKAY);
        add_row(RD, 1, 8'h52, 32'h0200, 4'd7, 3'd2, BURST_INCR, 32'h0, 4'h0, RESP_OKAY);
        add_row(RD, 1, 8'h53, 32'h1_0000, 4'd1, 3'd2, BURST_INCR, 32'h0, 4'h0, RESP_DECERR);
        add_row(RD, 1, 8'h54, 32'h0100, 4'd2, 3'd2, BURST_FIXED, 32'h0, 4'h0, RESP_OKAY);
        add_row(WR, 1, 8'h61, 32'hFFF8, 4'd3, 3'd2, BURST_INCR, 32'h5150_0000, 4'hF, RESP_OKAY);
        add_row(RD, 1, 8'h62, 32'hFFF8, 4'd3, 3'd2, BURST_INCR, 32'h0, 4'h0, RESP_OKAY);
        add_row(RD, 1, 8'h63, 32'h0000, 4'd3, 3'd2, BURST_INCR, 32'h0, 4'h0, RESP_OKAY);

        foreach (rows[i])
            cycle_limit += (int'(rows[i].len) + 1) * 8;
        cycle_limit += 100;

        repeat (2) @(posedge ACLK);
        ARESETn <= 1'b1;

        foreach (rows[i]) begin
            err_before = n_errors;
            if (rows[i].is_wr)
                do_write(rows[i]);
            else
                do_read(rows[i]);
            $display("row %0d %s id %02h addr %08h len %0d: %s", i,
                     rows[i].is_wr ? "write" : "read", rows[i].id, rows[i].addr,
                     rows[i].len, (n_errors == err_before) ? "ok" : "FAIL");
        end

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: src/axi_sram_slave.sv
module axi_sram_slave (
    input  logic                 ACLK,
    input  logic                 ARESETn,
    input  axi_sram_pkg::id_t    awid,
    input  axi_sram_pkg::addr_t  awaddr,
    input  axi_sram_pkg::len_t   awlen,
    input  axi_sram_pkg::size_t  awsize,
    input  axi_sram_pkg::burst_t awburst,
    input  logic                 awvalid,
    output logic                 awready,
    input  axi_sram_pkg::data_t  wdata,
    input  axi_sram_pkg::strb_t  wstrb,
    input  logic                 wlast,
    input  logic                 wvalid,
    output logic                 wready,
    output axi_sram_pkg::id_t    bid,
    output axi_sram_pkg::resp_t  bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  axi_sram_pkg::id_t    arid,
    input  axi_sram_pkg::addr_t  araddr,
    input  axi_sram_pkg::len_t   arlen,
    input  axi_sram_pkg::size_t  arsize,
    input  axi_sram_pkg::burst_t arburst,
    input  logic                 arvalid,
    output logic                 arready,
    output axi_sram_pkg::id_t    rid,
    output axi_sram_pkg::data_t  rdata,
    output axi_sram_pkg::resp_t  rresp,
    output logic                 rlast,
    output logic                 rvalid,
    input  logic                 rready
);
    import axi_sram_pkg::*;

    // write engine to bank
    logic       wr_en;
    word_addr_t wr_word_addr;
    data_t      wr_data;
    strb_t      wr_strb;

    // read engine to bank
    logic       rd_req;
    word_addr_t rd_word_addr;
    logic       rd_grant;
    data_t      rd_data;

    axi_write_engine u_write (.*);

    sram_bank u_bank (.*);

    axi_read_engine u_read (.*);

endmodule

// File: src/axi_read_engine.sv
`include "axi_sram_params.svh"

module axi_read_engine (
    input  logic                     ACLK,
    input  logic                     ARESETn,
    input  axi_sram_pkg::id_t        arid,
    input  axi_sram_pkg::addr_t      araddr,
    input  axi_sram_pkg::len_t       arlen,
    input  axi_sram_pkg::size_t      arsize,
    input  axi_sram_pkg::burst_t     arburst,
    input  logic                     arvalid,
    output logic                     arready,
    output axi_sram_pkg::id_t        rid,
    output axi_sram_pkg::data_t      rdata,
    output axi_sram_pkg::resp_t      rresp,
    output logic                     rlast,
    output logic                     rvalid,
    input  logic                     rready,
    output logic                     rd_req,
    output axi_sram_pkg::word_addr_t rd_word_addr,
    input  logic                     rd_grant,
    input  axi_sram_pkg::data_t      rd_data
);
    import axi_sram_pkg::*;

    rd_state_t state, state_nxt;
    len_t      beat_cnt;   // beats already handed over
    id_t       ar_id;
    addr_t     cur_addr;
    len_t      ar_len;
    size_t     ar_size;
    burst_t    ar_burst;
    resp_t     ar_resp;

    logic ar_fire;
    logic r_fire;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    assign arready = (state == RD_IDLE);
    assign rd_req  = (state == RD_FETCH);
    assign rvalid  = (state == RD_HOLD);

    assign rd_word_addr = cur_addr[`SRAM_WORD_ADDR_BITS+1:2];
    assign rid          = ar_id;
    assign rresp        = ar_resp;
    assign rdata        = (ar_resp == RESP_OKAY) ? rd_data : '0;  // error beats carry zero
    assign rlast        = rvalid && (beat_cnt == ar_len);

    always_comb begin
        state_nxt = state;
        unique case (state)
            RD_IDLE: begin
                if (ar_fire) begin
                    // error bursts never go near the bank
                    if (burst_resp(araddr, arsize) == RESP_OKAY)
                        state_nxt = RD_FETCH;
                    else
                        state_nxt = RD_HOLD;
                end
            end
            RD_FETCH: if (rd_grant) state_nxt = RD_HOLD;  // data lands next cycle
            RD_HOLD: begin
                if (r_fire) begin
                    if (rlast)
                        state_nxt = RD_IDLE;
                    else if (ar_resp == RESP_OKAY)
                        state_nxt = RD_FETCH;
                end
            end
            default: state_nxt = RD_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state    <= RD_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (ar_fire)
                beat_cnt <= '0;
            else if (r_fire)
                beat_cnt <= beat_cnt + len_t'(1);
        end
    end

    always_ff @(posedge ACLK) begin
        if (ar_fire) begin
            ar_id    <= arid;
            cur_addr <= araddr;
            ar_len   <= arlen;
            ar_size  <= arsize;
            ar_burst <= arburst;
            ar_resp  <= burst_resp(araddr, arsize);
        end else if (r_fire && ar_burst == BURST_INCR) begin
            cur_addr <= cur_addr + (addr_t'(1) << ar_size);
        end
    end

    // bank must keep its word while the master stalls
    a_r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast));

endmodule

// File: src/sram_bank.sv
`include "axi_sram_params.svh"

module sram_bank (
    input  logic                     ACLK,
    input  logic                     wr_en,
    input  axi_sram_pkg::word_addr_t wr_word_addr,
    input  axi_sram_pkg::data_t      wr_data,
    input  axi_sram_pkg::strb_t      wr_strb,
    input  logic                     rd_req,
    input  axi_sram_pkg::word_addr_t rd_word_addr,
    output logic                     rd_grant,
    output axi_sram_pkg::data_t      rd_data
);
    import axi_sram_pkg::*;

    data_t mem [`SRAM_DEPTH];

    // single port where writes always win
    assign rd_grant = rd_req && !wr_en;

    always_ff @(posedge ACLK) begin
        if (wr_en) begin
            for (int lane = 0; lane < `AXI_STRB_BITS; lane++) begin
                if (wr_strb[lane])
                    mem[wr_word_addr][lane*8 +: 8] <= wr_data[lane*8 +: 8];  // byte merge
            end
        end
    end

    // word is held until the next granted read
    always_ff @(posedge ACLK) begin
        if (rd_grant)
            rd_data <= mem[rd_word_addr];
    end

    // a refused read is not queued here, so the requester must hold it
    a_req_held: assert property (@(posedge ACLK)
        rd_req && !rd_grant |=> rd_req && $stable(rd_word_addr));

endmodule

// File: src/axi_write_engine.sv
`include "axi_sram_params.svh"

module axi_write_engine (
    input  logic                    ACLK,
    input  logic                    ARESETn,
    input  axi_sram_pkg::id_t       awid,
    input  axi_sram_pkg::addr_t     awaddr,
    input  axi_sram_pkg::len_t      awlen,
    input  axi_sram_pkg::size_t     awsize,
    input  axi_sram_pkg::burst_t    awburst,
    input  logic                    awvalid,
    output logic                    awready,
    input  axi_sram_pkg::data_t     wdata,
    input  axi_sram_pkg::strb_t     wstrb,
    input  logic                    wlast,
    input  logic                    wvalid,
    output logic                    wready,
    output axi_sram_pkg::id_t       bid,
    output axi_sram_pkg::resp_t     bresp,
    output logic                    bvalid,
    input  logic                    bready,
    output logic                    wr_en,
    output axi_sram_pkg::word_addr_t wr_word_addr,
    output axi_sram_pkg::data_t     wr_data,
    output axi_sram_pkg::strb_t     wr_strb
);
    import axi_sram_pkg::*;

    wr_state_t state, state_nxt;
    len_t      beats_left;   // address steps still allowed
    id_t       aw_id;
    addr_t     cur_addr;
    size_t     aw_size;
    burst_t    aw_burst;
    resp_t     aw_resp;

    logic aw_fire;
    logic w_fire;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    assign awready = (state == WR_IDLE);
    assign wready  = (state == WR_DATA);
    assign bvalid  = (state == WR_RESP);
    assign bid     = aw_id;
    assign bresp   = aw_resp;

    // data sits in its lane already, strobes pass straight through
    assign wr_en        = w_fire && (aw_resp == RESP_OKAY);
    assign wr_word_addr = cur_addr[`SRAM_WORD_ADDR_BITS+1:2];  // wraps modulo bank size
    assign wr_data      = wdata;
    assign wr_strb      = wstrb;

    always_comb begin
        state_nxt = state;
        unique case (state)
            WR_IDLE: if (aw_fire) state_nxt = WR_DATA;
            WR_DATA: if (w_fire && wlast) state_nxt = WR_RESP;  // wlast closes the burst
            WR_RESP: if (bready) state_nxt = WR_IDLE;
            default: state_nxt = WR_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state      <= WR_IDLE;
            beats_left <= '0;
        end else begin
            state <= state_nxt;
            if (aw_fire)
                beats_left <= awlen;
            else if (w_fire && beats_left != '0)
                beats_left <= beats_left - len_t'(1);
        end
    end

    always_ff @(posedge ACLK) begin
        if (aw_fire) begin
            aw_id    <= awid;
            cur_addr <= awaddr;
            aw_size  <= awsize;
            aw_burst <= awburst;
            aw_resp  <= burst_resp(awaddr, awsize);
        end else if (w_fire && aw_burst == BURST_INCR && beats_left != '0) begin
            cur_addr <= cur_addr + (addr_t'(1) << aw_size);  // fixed bursts keep the address
        end
    end

    // response is held with its payload until the master takes it
    a_b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp));

endmodule

// File: src/axi_sram_pkg.sv
`include "axi_sram_params.svh"

package axi_sram_pkg;

    typedef logic [`AXI_ADDR_BITS-1:0]       addr_t;
    typedef logic [`AXI_DATA_BITS-1:0]       data_t;
    typedef logic [`AXI_STRB_BITS-1:0]       strb_t;
    typedef logic [`AXI_ID_BITS-1:0]         id_t;
    typedef logic [`AXI_LEN_BITS-1:0]        len_t;
    typedef logic [`AXI_SIZE_BITS-1:0]       size_t;
    typedef logic [`SRAM_WORD_ADDR_BITS-1:0] word_addr_t;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } burst_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    typedef enum logic [1:0] {
        WR_IDLE = 2'b00,
        WR_DATA = 2'b01,
        WR_RESP = 2'b10
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE  = 2'b00,
        RD_FETCH = 2'b01,
        RD_HOLD  = 2'b10
    } rd_state_t;

    // error class of a burst, judged once at the address phase
    function automatic resp_t burst_resp(addr_t addr, size_t size);
        if (size > size_t'(`AXI_MAX_SIZE))
            return RESP_SLVERR;
        else if (addr >= (addr_t'(1) << `SRAM_BYTE_ADDR_BITS))
            return RESP_DECERR;
        else
            return RESP_OKAY;
    endfunction

endpackage

// File: src/axi_sram_params.svh
`ifndef AXI_SRAM_PARAMS_SVH
`define AXI_SRAM_PARAMS_SVH

// AXI field widths
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4
`define AXI_ID_BITS   8
`define AXI_LEN_BITS  4
`define AXI_SIZE_BITS 3

// sram geometry, word index width
`define SRAM_WORD_ADDR_BITS 14
`define SRAM_DEPTH          (1 << `SRAM_WORD_ADDR_BITS)

// byte address bits covered by the bank, 64 KiB
`define SRAM_BYTE_ADDR_BITS (`SRAM_WORD_ADDR_BITS + 2)

// largest legal size code, 4 bytes per beat
`define AXI_MAX_SIZE 2

`endif
